//--- project.f
verilog/fb_pkg.sv
verilog/display_timings.sv
verilog/box_drawer.sv
verilog/framebuffer.sv
verilog/pixel_reader.sv
verilog/fb_display_top.sv
sim/fb_display_tb.sv

//--- sim/draw_cases.txt
# colour index in hex, then frames to wait before the checked frame
# one border draw per line
4 0
9 1
2 0
f 0
0 1
c 0
7 0
e 1

//--- sim/fb_display_tb.sv
// fb_display_tb
// draws borders from a case file and checks whole output frames
// against a reference framebuffer

`timescale 1ns/1ns
`default_nettype none

module fb_display_tb import fb_pkg::*; ();

    localparam int CLK_NS      = 100;
    localparam int FRAME_CYC   = H_TOTAL * V_TOTAL;

    logic   clk_pix = 1'b0;
    logic   rst;
    logic   draw_start;
    cidx_t  draw_cidx;
    video_t video;
    logic   draw_busy;

    cidx_t  ref_fb [FB_HEIGHT][FB_WIDTH];  // expected framebuffer contents
    cidx_t  case_cidx [$];
    int     case_settle [$];
    logic   cases_loaded = 1'b0;
    integer seed;

    fb_display_top i_fb_display_top (
        .clk_pix    (clk_pix),
        .rst        (rst),
        .draw_start (draw_start),
        .draw_cidx  (draw_cidx),
        .video      (video),
        .draw_busy  (draw_busy)
    );

    always #(CLK_NS / 2) clk_pix = ~clk_pix;

    task automatic abort_run();
        $display("ERRORS FOUND");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_video(video_t got, video_t exp);
        if (got !== exp) begin
            $write("Mismatch video at %0t: got hsync=%h vsync=%h de=%h rgb=%h%h%h",
                   $time, got.hsync, got.vsync, got.de, got.red, got.green, got.blue);
            $display(", expected hsync=%h vsync=%h de=%h rgb=%h%h%h",
                     exp.hsync, exp.vsync, exp.de, exp.red, exp.green, exp.blue);
            abort_run();
        end
    endtask

    task automatic check_busy(logic got, logic exp);
        if (got !== exp) begin
            $display("Mismatch draw_busy at %0t: got %h, expected %h", $time, got, exp);
            abort_run();
        end
    endtask

    task automatic load_cases();
        int    fd;
        string line;
        int    c;
        int    s;
        fd = $fopen("sim/draw_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open the draw case file");
            abort_run();
        end
        while (!$feof(fd)) begin
            line = "";
            if ($fgets(line, fd) > 0 && line.len() > 0 && line[0] != "#") begin
                if ($sscanf(line, "%h %d", c, s) == 2) begin
                    case_cidx.push_back(cidx_t'(c));
                    case_settle.push_back(s);
                end
            end
        end
        $fclose(fd);
    endtask

    // raster position x, y as seen at the output
    function automatic video_t expected_video(int x, int y);
        video_t v;
        int     fx;
        int     fy;
        v       = '0;
        v.hsync = (x >= H_SYNC_START) && (x < H_SYNC_END);
        v.vsync = (y >= V_SYNC_START) && (y < V_SYNC_END);
        v.de    = (x < H_RES) && (y < V_RES);
        if (v.de) begin
            fx = x >> FB_SCALE_SHIFT;
            fy = y >> FB_SCALE_SHIFT;
            {v.red, v.green, v.blue} = PALETTE[ref_fb[fy][fx]];
        end
        return v;
    endfunction

    // returns on the sample where the output vsync goes high
    task automatic wait_vsync();
        logic prev;
        prev = video.vsync;
        @(negedge clk_pix);
        while (prev || !video.vsync) begin
            prev = video.vsync;
            @(negedge clk_pix);
        end
    endtask

    task automatic check_frame();
        int x;
        int y;
        x = 0;
        y = V_SYNC_START;  // vsync rises at column 0 of this row
        repeat (FRAME_CYC) begin
            check_video(video, expected_video(x, y));
            x++;
            if (x == H_TOTAL) begin
                x = 0;
                y = (y == V_TOTAL - 1) ? 0 : y + 1;
            end
            @(negedge clk_pix);
        end
    endtask

    task automatic update_ref(cidx_t c);
        for (int y = 0; y < FB_HEIGHT; y++) begin
            for (int x = 0; x < FB_WIDTH; x++) begin
                if (x == 0 || x == FB_WIDTH - 1 || y == 0 || y == FB_HEIGHT - 1) begin
                    ref_fb[y][x] = c;
                end
            end
        end
    endtask

    task automatic run_draw(cidx_t c);
        int gap;
        int waited;
        gap = $unsigned($random(seed)) % 16;
        repeat (gap) @(negedge clk_pix);
        check_busy(draw_busy, 1'b0);
        draw_cidx  = c;
        draw_start = 1'b1;
        @(negedge clk_pix);
        draw_start = 1'b0;
        check_busy(draw_busy, 1'b1);
        // a second start with another colour must be ignored
        gap = $unsigned($random(seed)) % 16;
        repeat (gap) @(negedge clk_pix);
        check_busy(draw_busy, 1'b1);
        draw_cidx  = ~c;
        draw_start = 1'b1;
        @(negedge clk_pix);
        draw_start = 1'b0;
        waited = 0;
        while (draw_busy && waited < 2 * FRAME_CYC) begin
            @(negedge clk_pix);
            waited++;
        end
        if (draw_busy) begin
            $display("draw_busy stayed high for more than two frames");
            abort_run();
        end
        update_ref(c);
    endtask

    initial begin
        rst        = 1'b1;
        draw_start = 1'b0;
        draw_cidx  = '0;
        seed       = 32'h0d6d2454;
        for (int y = 0; y < FB_HEIGHT; y++) begin
            for (int x = 0; x < FB_WIDTH; x++) begin
                ref_fb[y][x] = '0;
            end
        end
        load_cases();
        cases_loaded = 1'b1;
        repeat (5) @(negedge clk_pix);
        rst = 1'b0;
        check_busy(draw_busy, 1'b0);
        wait_vsync();
        check_frame();  // blank screen before any draw
        foreach (case_cidx[i]) begin
            run_draw(case_cidx[i]);
            repeat (case_settle[i]) wait_vsync();
            wait_vsync();
            check_frame();
        end
        $display("NO ERRORS");
        $finish;
    end

    // watchdog allows four frames per case plus slack
    initial begin
        longint limit_ns;
        wait (cases_loaded);
        limit_ns = longint'(case_cidx.size() + 2) * 4 * FRAME_CYC * CLK_NS;
        #(limit_ns);
        $display("timeout, the test did not finish in the expected time");
        abort_run();
    end

endmodule

`default_nettype wire

//--- verilog/box_drawer.sv
// box_drawer
// writes a one-pixel border of one palette index around the framebuffer
// with one req/ack handshake per pixel

`timescale 1ns/1ns
`default_nettype none

module box_drawer import fb_pkg::*; (
    input  wire logic  clk_pix,
    input  wire logic  rst,
    input  wire logic  draw_start,
    input  wire cidx_t draw_cidx,
    input  wire logic  frame,
    output fb_wr_t     wr,
    output logic       wr_req,
    input  wire logic  wr_ack,
    output logic       draw_busy
);

    typedef enum logic [2:0] {IDLE, ARMED, TOP, RIGHT, LEFT, BOTTOM} draw_state_t;

    draw_state_t         state;
    draw_state_t         next_edge;
    logic [FB_ADDRW-1:0] cnt_draw;   // pixel within current edge
    logic [FB_ADDRW-1:0] last_idx;
    fb_addr_t            addr_step;
    fb_addr_t            next_start;
    logic                hs_done;
    logic                edge_last;

    // per-edge geometry
    always_comb begin
        addr_step  = fb_addr_t'(1);
        last_idx   = FB_ADDRW'(FB_WIDTH - 1);
        next_start = '0;
        next_edge  = IDLE;
        case (state)
            TOP: begin
                next_start = fb_addr_t'(FB_WIDTH - 1);  // right column, top row
                next_edge  = RIGHT;
            end
            RIGHT: begin
                addr_step = fb_addr_t'(FB_WIDTH);
                last_idx  = FB_ADDRW'(FB_HEIGHT - 1);
                next_edge = LEFT;
            end
            LEFT: begin
                addr_step  = fb_addr_t'(FB_WIDTH);
                last_idx   = FB_ADDRW'(FB_HEIGHT - 1);
                next_start = fb_addr_t'(FB_WIDTH * (FB_HEIGHT - 1));
                next_edge  = BOTTOM;
            end
            default: ;  // bottom edge finishes the draw
        endcase
    end

    assign hs_done   = wr_req && wr_ack;
    assign edge_last = (cnt_draw == last_idx);
    assign draw_busy = (state != IDLE);

    always_ff @(posedge clk_pix) begin
        if (rst) begin
            state    <= IDLE;
            wr_req   <= 1'b0;
            cnt_draw <= '0;
        end else begin
            case (state)
                IDLE: if (draw_start) state <= ARMED;
                ARMED: begin
                    if (frame) begin
                        cnt_draw <= '0;
                        state    <= TOP;
                    end
                end
                default: begin
                    if (!wr_req && !wr_ack) begin
                        wr_req <= 1'b1;  // previous handshake fully closed
                    end else if (hs_done) begin
                        wr_req <= 1'b0;
                        if (edge_last) begin
                            cnt_draw <= '0;
                            state    <= next_edge;
                        end else begin
                            cnt_draw <= cnt_draw + 1'b1;
                        end
                    end
                end
            endcase
        end
    end

    // write payload only moves while wr_req is low
    always_ff @(posedge clk_pix) begin
        if (state == IDLE && draw_start) wr.cidx <= draw_cidx;
        if (state == ARMED && frame) begin
            wr.addr <= '0;
        end else if (hs_done) begin
            wr.addr <= edge_last ? next_start : wr.addr + addr_step;
        end
    end

    a_wr_stable: assert property (
        @(posedge clk_pix) disable iff (rst)
        (wr_req && !wr_ack) |=> $stable(wr)
    ) else $error("write payload changed during handshake");

endmodule

`default_nettype wire

//--- verilog/display_timings.sv
// display_timings
// raster counters with registered sync, data enable and frame start

`timescale 1ns/1ns
`default_nettype none

module display_timings import fb_pkg::*; (
    input  wire logic clk_pix,
    input  wire logic rst,
    output coord_t    sx,
    output coord_t    sy,
    output logic      hsync,
    output logic      vsync,
    output logic      de,
    output logic      frame
);

    coord_t sx_nxt;
    coord_t sy_nxt;

    // next position wraps at the totals
    always_comb begin
        sx_nxt = sx + 1'b1;
        sy_nxt = sy;
        if (sx == COORD_W'(H_TOTAL - 1)) begin
            sx_nxt = '0;
            if (sy == COORD_W'(V_TOTAL - 1)) begin
                sy_nxt = '0;
            end else begin
                sy_nxt = sy + 1'b1;
            end
        end
    end

    // decode from the next position so flags line up with sx/sy
    always_ff @(posedge clk_pix) begin
        if (rst) begin
            sx    <= '0;
            sy    <= '0;
            hsync <= 1'b0;
            vsync <= 1'b0;
            de    <= 1'b1;  // position 0,0 is active
            frame <= 1'b1;
        end else begin
            sx    <= sx_nxt;
            sy    <= sy_nxt;
            hsync <= (sx_nxt >= COORD_W'(H_SYNC_START)) && (sx_nxt < COORD_W'(H_SYNC_END));
            vsync <= (sy_nxt >= COORD_W'(V_SYNC_START)) && (sy_nxt < COORD_W'(V_SYNC_END));
            de    <= (sx_nxt < COORD_W'(H_RES)) && (sy_nxt < COORD_W'(V_RES));
            frame <= (sx_nxt == '0) && (sy_nxt == '0);
        end
    end

    // horizontal count never leaves the line
    a_sx_range: assert property (
        @(posedge clk_pix) disable iff (rst)
        sx < COORD_W'(H_TOTAL)
    ) else $error("sx out of range: %0d", sx);

endmodule

`default_nettype wire

//--- verilog/fb_display_top.sv
// fb_display_top
// display timings, box drawer, framebuffer and pixel reader wired together

`timescale 1ns/1ns
`default_nettype none

module fb_display_top import fb_pkg::*; (
    input  wire logic  clk_pix,
    input  wire logic  rst,
    input  wire logic  draw_start,
    input  wire cidx_t draw_cidx,
    output video_t     video,
    output logic       draw_busy
);

    coord_t   sx;
    coord_t   sy;
    logic     hsync;
    logic     vsync;
    logic     de;
    logic     frame;
    fb_wr_t   wr;       // drawer to framebuffer
    logic     wr_req;
    logic     wr_ack;
    fb_addr_t rd_addr;  // reader to framebuffer
    cidx_t    rd_cidx;

    display_timings i_display_timings (
        .clk_pix (clk_pix),
        .rst     (rst),
        .sx      (sx),
        .sy      (sy),
        .hsync   (hsync),
        .vsync   (vsync),
        .de      (de),
        .frame   (frame)
    );

    box_drawer i_box_drawer (
        .clk_pix    (clk_pix),
        .rst        (rst),
        .draw_start (draw_start),
        .draw_cidx  (draw_cidx),
        .frame      (frame),
        .wr         (wr),
        .wr_req     (wr_req),
        .wr_ack     (wr_ack),
        .draw_busy  (draw_busy)
    );

    framebuffer i_framebuffer (
        .clk_pix (clk_pix),
        .rst     (rst),
        .wr      (wr),
        .wr_req  (wr_req),
        .wr_ack  (wr_ack),
        .rd_addr (rd_addr),
        .rd_cidx (rd_cidx)
    );

    pixel_reader i_pixel_reader (
        .clk_pix (clk_pix),
        .rst     (rst),
        .sx      (sx),
        .sy      (sy),
        .hsync   (hsync),
        .vsync   (vsync),
        .de      (de),
        .rd_addr (rd_addr),
        .rd_cidx (rd_cidx),
        .video   (video)
    );

endmodule

`default_nettype wire

//--- verilog/fb_pkg.sv
// fb_pkg
// shared sizes, types and palette for the framebuffer display pipeline

`default_nettype none

package fb_pkg;

    // active and total raster
    localparam int H_RES   = 32;
    localparam int V_RES   = 24;
    localparam int H_TOTAL = 40;
    localparam int V_TOTAL = 28;

    localparam int H_SYNC_START = 34;  // sync active from start up to end-1
    localparam int H_SYNC_END   = 37;
    localparam int V_SYNC_START = 25;
    localparam int V_SYNC_END   = 27;

    // framebuffer is the raster scaled down by 4 each way
    localparam int FB_SCALE_SHIFT = 2;
    localparam int FB_WIDTH       = H_RES >> FB_SCALE_SHIFT;
    localparam int FB_HEIGHT      = V_RES >> FB_SCALE_SHIFT;
    localparam int FB_PIXELS      = FB_WIDTH * FB_HEIGHT;
    localparam int FB_ADDRW       = $clog2(FB_PIXELS);

    localparam int CIDX_W      = 4;
    localparam int COORD_W     = 8;
    localparam int DISPLAY_LAT = 3;  // address reg, RAM read, output reg

    typedef logic [COORD_W-1:0]  coord_t;
    typedef logic [FB_ADDRW-1:0] fb_addr_t;
    typedef logic [CIDX_W-1:0]   cidx_t;
    typedef logic [3:0]          colour_t;

    typedef struct packed {
        fb_addr_t addr;
        cidx_t    cidx;
    } fb_wr_t;

    typedef struct packed {
        logic    hsync;
        logic    vsync;
        logic    de;
        colour_t red;
        colour_t green;
        colour_t blue;
    } video_t;

    // 12-bit RGB in ega-like ordering
    localparam logic [11:0] PALETTE [0:15] = '{
        12'h000, 12'h00A, 12'h0A0, 12'h0AA,
        12'hA00, 12'hA0A, 12'hA50, 12'hAAA,
        12'h555, 12'h55F, 12'h5F5, 12'h5FF,
        12'hF55, 12'hF5F, 12'hFF5, 12'hFFF
    };

endpackage

`default_nettype wire

//--- verilog/framebuffer.sv
// framebuffer
// pixel index memory, handshaked write port and one-cycle read port

`timescale 1ns/1ns
`default_nettype none

module framebuffer import fb_pkg::*; (
    input  wire logic     clk_pix,
    input  wire logic     rst,
    input  wire fb_wr_t   wr,
    input  wire logic     wr_req,
    output logic          wr_ack,
    input  wire fb_addr_t rd_addr,
    output cidx_t         rd_cidx
);

    typedef enum logic {WAIT_REQ, ACKED} wr_state_t;

    wr_state_t wr_state;
    cidx_t     mem [FB_PIXELS];
    logic      store;

    // screen starts black
    initial begin
        for (int i = 0; i < FB_PIXELS; i++) begin
            mem[i] = '0;
        end
    end

    assign store  = (wr_state == WAIT_REQ) && wr_req;  // first req cycle only
    assign wr_ack = (wr_state == ACKED);

    always_ff @(posedge clk_pix) begin
        if (rst) begin
            wr_state <= WAIT_REQ;
        end else begin
            case (wr_state)
                WAIT_REQ: if (wr_req) wr_state <= ACKED;
                ACKED:    if (!wr_req) wr_state <= WAIT_REQ;  // drop ack after req
                default:  wr_state <= WAIT_REQ;
            endcase
        end
    end

    always_ff @(posedge clk_pix) begin
        if (store) mem[wr.addr] <= wr.cidx;
    end

    always_ff @(posedge clk_pix) begin
        rd_cidx <= mem[rd_addr];
    end

    // drawer must stay inside the pixel array
    a_wr_addr: assert property (
        @(posedge clk_pix) disable iff (rst)
        store |-> (wr.addr < FB_PIXELS)
    ) else $error("write address %0d beyond framebuffer", wr.addr);

endmodule

`default_nettype wire

//--- verilog/pixel_reader.sv
// pixel_reader
// scales screen position to a framebuffer address, looks up the colour
// and realigns sync and de with the pixel

`timescale 1ns/1ns
`default_nettype none

module pixel_reader import fb_pkg::*; (
    input  wire logic   clk_pix,
    input  wire logic   rst,
    input  wire coord_t sx,
    input  wire coord_t sy,
    input  wire logic   hsync,
    input  wire logic   vsync,
    input  wire logic   de,
    output fb_addr_t    rd_addr,
    input  wire cidx_t  rd_cidx,
    output video_t      video
);

    coord_t                 fx;
    coord_t                 fy;
    fb_addr_t               addr_calc;
    logic [DISPLAY_LAT-2:0] hsync_sr;  // covers address and RAM stages
    logic [DISPLAY_LAT-2:0] vsync_sr;
    logic [DISPLAY_LAT-2:0] de_sr;
    logic [11:0]            clut;
    colour_t                red;
    colour_t                green;
    colour_t                blue;

    always_comb begin
        fx        = sx >> FB_SCALE_SHIFT;
        fy        = sy >> FB_SCALE_SHIFT;
        addr_calc = fb_addr_t'(fy * FB_WIDTH + fx);
    end

    // stage 1 holds the address during blanking so it stays in range
    always_ff @(posedge clk_pix) begin
        if (rst) begin
            rd_addr <= '0;
        end else if (de) begin
            rd_addr <= addr_calc;
        end
    end

    // stages 1 and 2 for the control signals
    always_ff @(posedge clk_pix) begin
        if (rst) begin
            hsync_sr <= '0;
            vsync_sr <= '0;
            de_sr    <= '0;
        end else begin
            hsync_sr <= {hsync_sr[DISPLAY_LAT-3:0], hsync};
            vsync_sr <= {vsync_sr[DISPLAY_LAT-3:0], vsync};
            de_sr    <= {de_sr[DISPLAY_LAT-3:0], de};
        end
    end

    assign clut = PALETTE[rd_cidx];

    // blank outside active area
    always_comb begin
        if (de_sr[DISPLAY_LAT-2]) begin
            {red, green, blue} = clut;
        end else begin
            {red, green, blue} = 12'h000;
        end
    end

    // stage 3
    always_ff @(posedge clk_pix) begin
        if (rst) begin
            video <= '0;
        end else begin
            video.hsync <= hsync_sr[DISPLAY_LAT-2];
            video.vsync <= vsync_sr[DISPLAY_LAT-2];
            video.de    <= de_sr[DISPLAY_LAT-2];
            video.red   <= red;
            video.green <= green;
            video.blue  <= blue;
        end
    end

endmodule

`default_nettype wire
